/* Makefile */
TOP := tb_adc_ctrl

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): project.f $(wildcard include/*.svh logic/*.sv dv/*.sv)
	verilator --binary --timing -f project.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* dv/adc3wire_model.sv */
// ADC serial port model; shifts MSB first on rising sclk while exactly one chip select is low.
`timescale 1ns/10ps
`default_nettype none

`include "adc_ctrl_params.svh"

module adc3wire_model (
  input  wire                      sclk,
  input  wire                      sdata,
  input  wire [0:`ADC_CS_COUNT-1]  cs,
  output logic [15:0]              frame_data,
  output int                       frame_cs,
  output int                       frame_done
);

  logic [15:0] shift_q = '0;
  logic [15:0] data_q = '0;
  logic        sclk_prev = 1'b0;
  int          sel_idx = -1; // No frame open.
  int          cs_q = -1;
  int          done_q = 0;

  always @(sclk or cs) begin
    int low_count;
    int low_idx;
    low_count = 0;
    low_idx = -1;
    for (int i = 0; i < `ADC_CS_COUNT; i++) begin
      if (!cs[i]) begin
        low_count++;
        low_idx = i;
      end
    end
    if (sclk && !sclk_prev && low_count == 1) begin
      shift_q = {shift_q[14:0], sdata};
      sel_idx = low_idx;
    end
    // Frame closes when its chip select goes high.
    if (sel_idx >= 0 && cs[sel_idx]) begin
      data_q = shift_q;
      cs_q = sel_idx;
      done_q++;
      sel_idx = -1;
      shift_q = '0;
    end
    sclk_prev = sclk;
  end

  assign frame_data = data_q;
  assign frame_cs   = cs_q;
  assign frame_done = done_q;

endmodule

`default_nettype wire

/* dv/tb_adc_ctrl.sv */
// Single-beat OPB master driving on the falling edge; ADC frames are 16 bits, MSB first.
`timescale 1ns/10ps
`default_nettype none

`include "adc_ctrl_params.svh"

module tb_adc_ctrl;

  localparam int          timeout_cycles = 2000; // Tests need about 200 cycles.
  localparam logic [31:0] addr_3wire = `ADC_BASEADDR + `ADC_REG_3WIRE_OFF;
  localparam logic [31:0] addr_ctrl  = `ADC_BASEADDR + `ADC_REG_CTRL_OFF;

  logic        OPB_Clk = 1'b0;
  logic        rst_n;
  logic [0:31] opb_abus;
  logic [0:3]  opb_be;
  logic [0:31] opb_dbus;
  logic        opb_rnw;
  logic        opb_select;
  logic [0:31] sl_dbus;
  logic        sl_xferack;
  logic        adc3wire_clk;
  logic        adc3wire_data;
  logic [0:3]  adc3wire_cs;
  logic        adc_reset;
  logic [0:4]  delay_tap;
  logic [0:15] delay_rst;
  logic [0:3]  iserdes_bitslip;
  logic [0:3]  load_phase_set;
  logic [15:0] frame_data;
  int          frame_cs;
  int          frame_done;
  logic [15:0] lfsr_q = 16'd44;
  logic [31:0] exp_regs [2]; // 0 is the 3-wire register, 1 the control register.
  string       test_name;
  int          cycle_count = 0;

  adc_ctrl_top uut (.*);

  adc3wire_model adc_model (
    .sclk       (adc3wire_clk),
    .sdata      (adc3wire_data),
    .cs         (adc3wire_cs),
    .frame_data (frame_data),
    .frame_cs   (frame_cs),
    .frame_done (frame_done)
  );

  always #20 OPB_Clk = ~OPB_Clk;

  always @(posedge OPB_Clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == timeout_cycles) begin
      $display("Run exceeded %0d cycles in test %s", timeout_cycles, test_name);
      $display("Verification failed");
      $fatal(1, "Timeout");
    end
  end

  // Taps 16, 14, 13, 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int nbits, output logic [31:0] w);
    w = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w = {w[30:0], lfsr_q[15]};
    end
  endtask

  // Lane 0 is the most significant byte.
  function automatic logic [31:0] merge_expected(input logic [31:0] old_word,
                                                 input logic [31:0] new_word,
                                                 input logic [0:3]  be);
    logic [31:0] mask;
    mask = {{8{be[0]}}, {8{be[1]}}, {8{be[2]}}, {8{be[3]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic check(input string what, input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error: %s, %s: expected %h actual %h", test_name, what, expected, actual);
      $display("Verification failed");
      $fatal(1, "Mismatch");
    end
  endtask

  task automatic fail_run(input string reason);
    $display("%s in test %s", reason, test_name);
    $display("Verification failed");
    $fatal(1, "%s", reason);
  endtask

  // Starts and ends on a falling edge.
  task automatic opb_transfer(input logic [31:0] addr, input logic rnw, input logic [0:3] be,
                              input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited = 0;
    opb_abus = addr;
    opb_be = be;
    opb_dbus = wdata;
    opb_rnw = rnw;
    opb_select = 1'b1;
    do begin
      @(negedge OPB_Clk);
      waited++;
      if (!sl_xferack) check("sl_dbus before ack", 32'h0, sl_dbus);
      if (waited > 8) fail_run("No acknowledge within 8 cycles");
    end while (!sl_xferack);
    rdata = sl_dbus;
    opb_select = 1'b0;
    opb_rnw = 1'b0;
    @(negedge OPB_Clk);
    check("xferack width", 32'h0, {31'h0, sl_xferack});
    check("sl_dbus after ack", 32'h0, sl_dbus);
  endtask

  task automatic opb_write(input logic [31:0] addr, input logic [0:3] be, input logic [31:0] data);
    logic [31:0] unused_rd;
    opb_transfer(addr, 1'b0, be, data, unused_rd);
  endtask

  task automatic opb_read(input logic [31:0] addr, output logic [31:0] data);
    opb_transfer(addr, 1'b1, 4'b0000, 32'h0, data);
  endtask

  task automatic reg_write(input int idx, input logic [0:3] be, input logic [31:0] value);
    opb_write(idx == 1 ? addr_ctrl : addr_3wire, be, value);
    exp_regs[idx] = merge_expected(exp_regs[idx], value, be);
  endtask

  task automatic read_back_all();
    logic [31:0] rd;
    opb_read(addr_3wire, rd);
    check("3-wire readback", exp_regs[0], rd);
    opb_read(addr_ctrl, rd);
    check("control readback", exp_regs[1], rd);
  endtask

  task automatic wire_write(input logic clk, input logic data, input logic [0:3] cs);
    logic [0:31] word;
    word = '0;
    word[0] = clk;
    word[1] = data;
    word[2:5] = cs;
    reg_write(0, 4'b1111, word);
  endtask

  // Expected pulses are the control bits that rise with this write.
  task automatic ctrl_write_strobes(input logic [31:0] value);
    logic [0:31] rise;
    rise = value & ~exp_regs[1];
    reg_write(1, 4'b1111, value);
    check("strobe pulse", 32'({rise[0:15], rise[21:24], rise[25:28]}),
          32'({delay_rst, iserdes_bitslip, load_phase_set}));
    @(negedge OPB_Clk);
    check("strobe end", 32'h0, 32'({delay_rst, iserdes_bitslip, load_phase_set}));
  endtask

  task automatic no_ack_access(input logic [31:0] addr, input logic rnw);
    opb_abus = addr;
    opb_be = 4'b1111;
    opb_dbus = 32'hFFFF_FFFF;
    opb_rnw = rnw;
    opb_select = 1'b1;
    repeat (8) begin
      @(negedge OPB_Clk);
      if (sl_xferack) fail_run("Acknowledge for an address outside the window");
    end
    opb_select = 1'b0;
    @(negedge OPB_Clk);
  endtask

  task automatic reset_state();
    test_name = "reset";
    read_back_all();
    check("pins", 32'h0, 32'({adc3wire_clk, adc3wire_data, adc3wire_cs, adc_reset, delay_tap}));
    check("strobes", 32'h0, 32'({delay_rst, iserdes_bitslip, load_phase_set}));
  endtask

  task automatic byte_enable_writes();
    logic [0:3]  be_list [5] = '{4'b1111, 4'b1000, 4'b0101, 4'b0010, 4'b0000};
    logic [31:0] w;
    test_name = "byte enables";
    for (int r = 0; r < 2; r++) begin
      foreach (be_list[i]) begin
        rand_bits(32, w);
        reg_write(r, be_list[i], w);
        read_back_all();
      end
    end
  endtask

  task automatic field_mapping();
    logic [31:0] w;
    logic [0:31] wb;
    test_name = "field mapping";
    rand_bits(32, w);
    reg_write(1, 4'b1111, w);
    wb = w;
    check("adc_reset", 32'(wb[29]), 32'(adc_reset));
    check("delay_tap", 32'(wb[16:20]), 32'(delay_tap));
    rand_bits(32, w);
    reg_write(0, 4'b1111, w);
    wb = w;
    check("3-wire pins", 32'(wb[0:5]), 32'({adc3wire_clk, adc3wire_data, adc3wire_cs}));
  endtask

  task automatic strobe_pulses();
    logic [31:0] v;
    test_name = "strobes";
    rand_bits(32, v);
    v = v | 32'h8000_0448; // At least one delay, bitslip and load bit.
    ctrl_write_strobes(32'h0);
    ctrl_write_strobes(v);
    ctrl_write_strobes(v);
    ctrl_write_strobes(v & 32'hFFFF_0000);
    ctrl_write_strobes(v);
    ctrl_write_strobes(32'h0);
    ctrl_write_strobes(v);
  endtask

  task automatic serial_frame();
    logic [31:0] w;
    int          done_before;
    test_name = "serial frame";
    rand_bits(16, w);
    wire_write(1'b0, 1'b0, 4'b1111);
    done_before = frame_done;
    wire_write(1'b0, 1'b0, 4'b1101);
    for (int i = 15; i >= 0; i--) begin
      wire_write(1'b0, w[i], 4'b1101);
      wire_write(1'b1, w[i], 4'b1101);
    end
    wire_write(1'b0, 1'b0, 4'b1101);
    wire_write(1'b0, 1'b0, 4'b1111);
    check("frame count", done_before + 1, frame_done);
    check("frame data", {16'h0, w[15:0]}, {16'h0, frame_data});
    check("frame cs", 32'd2, frame_cs);
  endtask

  task automatic out_of_window_access();
    test_name = "out of window";
    no_ack_access(`ADC_HIGHADDR + 1, 1'b0);
    no_ack_access(`ADC_BASEADDR - 4, 1'b0);
    no_ack_access(`ADC_HIGHADDR + 1, 1'b1);
    read_back_all();
  endtask

  initial begin
    test_name = "init";
    rst_n = 1'b0;
    opb_abus = '0;
    opb_be = '0;
    opb_dbus = '0;
    opb_rnw = 1'b0;
    opb_select = 1'b0;
    exp_regs[0] = '0;
    exp_regs[1] = '0;
    repeat (2) @(negedge OPB_Clk);
    rst_n = 1'b1;
    reset_state();
    byte_enable_writes();
    field_mapping();
    strobe_pulses();
    serial_frame();
    out_of_window_access();
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

/* include/adc_ctrl_params.svh */
// Window is two words; only offset bit 2 is decoded. Bit numbers are big-endian with bit 0 the MSB.
`ifndef ADC_CTRL_PARAMS_SVH
`define ADC_CTRL_PARAMS_SVH

// OPB byte address window.
`define ADC_BASEADDR      32'h0001_0000
`define ADC_HIGHADDR      32'h0001_0007
`define ADC_REG_SEL_BIT   2

// Register byte offsets inside the window.
`define ADC_REG_3WIRE_OFF 32'h0000_0000
`define ADC_REG_CTRL_OFF  32'h0000_0004

`define ADC_CS_COUNT      4
`define ADC_DELAY_LANES   16
`define ADC_TAP_WIDTH     5
`define ADC_SERDES_LANES  4

// First bit of each field.
`define ADC_3W_CLK_BIT    0
`define ADC_3W_DATA_BIT   1
`define ADC_3W_CS_BIT     2
`define ADC_CTRL_DLY_BIT  0
`define ADC_CTRL_TAP_BIT  16
`define ADC_CTRL_SLIP_BIT 21
`define ADC_CTRL_LOAD_BIT 25
`define ADC_CTRL_RST_BIT  29

`endif

/* logic/adc_ctrl_pkg.sv */
// Both enums are one bit wide; a third register or bus state needs wider types.
`default_nettype none

package adc_ctrl_pkg;

  // Register picked by offset bit 2 of the byte address.
  typedef enum logic {
    REG_3WIRE = 1'b0, // Offset 0.
    REG_CTRL  = 1'b1  // Offset 4.
  } reg_sel_e;

  // Slave bus state.
  // ST_ACK lasts one cycle and is always followed by ST_IDLE,
  // so a master that holds select is acknowledged every second cycle.
  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_ACK  = 1'b1
  } opb_state_e;

endpackage

`default_nettype wire

/* logic/adc_ctrl_regs.sv */
// Both registers are fully readable; bits outside the defined fields are stored but drive no pin.
`timescale 1ns/10ps
`default_nettype none

`include "adc_ctrl_params.svh"

module adc_ctrl_regs
  import adc_ctrl_pkg::*;
(
  input  wire                            OPB_Clk,
  input  wire                            rst_n,
  input  wire                            wr_en,
  input  wire reg_sel_e                  wr_sel,
  input  wire  [0:3]                     wr_be,
  input  wire  [0:31]                    wr_data,
  output logic [0:31]                    rd_3wire,
  output logic [0:31]                    rd_ctrl,
  output logic                           adc3wire_clk,
  output logic                           adc3wire_data,
  output logic [0:`ADC_CS_COUNT-1]       adc3wire_cs,
  output logic                           adc_reset,
  output logic [0:`ADC_TAP_WIDTH-1]      delay_tap,
  output logic [0:`ADC_DELAY_LANES-1]    delay_rst_lvl,
  output logic [0:`ADC_SERDES_LANES-1]   bitslip_lvl,
  output logic [0:`ADC_SERDES_LANES-1]   load_phase_lvl
);

  logic [0:31] reg_3wire_q;
  logic [0:31] reg_ctrl_q;

  // Byte lane n covers bits 8n to 8n+7.
  function automatic logic [0:31] merge_lanes(input logic [0:31] old_word,
                                              input logic [0:31] new_word,
                                              input logic [0:3]  be);
    logic [0:31] word;
    word = old_word;
    for (int lane = 0; lane < 4; lane++) begin
      if (be[lane]) begin
        word[lane*8 +: 8] = new_word[lane*8 +: 8];
      end
    end
    return word;
  endfunction

  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      reg_3wire_q <= '0;
      reg_ctrl_q  <= '0;
    end else if (wr_en) begin
      if (wr_sel == REG_CTRL) begin
        reg_ctrl_q <= merge_lanes(reg_ctrl_q, wr_data, wr_be);
      end else begin
        reg_3wire_q <= merge_lanes(reg_3wire_q, wr_data, wr_be);
      end
    end
  end

  assign rd_3wire = reg_3wire_q;
  assign rd_ctrl  = reg_ctrl_q;

  // Serial port pins, toggled by software.
  assign adc3wire_clk  = reg_3wire_q[`ADC_3W_CLK_BIT];
  assign adc3wire_data = reg_3wire_q[`ADC_3W_DATA_BIT];
  assign adc3wire_cs   = reg_3wire_q[`ADC_3W_CS_BIT +: `ADC_CS_COUNT]; // Active low at the ADC.

  assign delay_rst_lvl  = reg_ctrl_q[`ADC_CTRL_DLY_BIT +: `ADC_DELAY_LANES];
  assign delay_tap      = reg_ctrl_q[`ADC_CTRL_TAP_BIT +: `ADC_TAP_WIDTH];
  assign bitslip_lvl    = reg_ctrl_q[`ADC_CTRL_SLIP_BIT +: `ADC_SERDES_LANES];
  assign load_phase_lvl = reg_ctrl_q[`ADC_CTRL_LOAD_BIT +: `ADC_SERDES_LANES];
  assign adc_reset      = reg_ctrl_q[`ADC_CTRL_RST_BIT];

endmodule

`default_nettype wire

/* logic/adc_ctrl_top.sv */
// OPB ADC control peripheral; strobes are one OPB_Clk cycle wide and need a same-clock receiver.
`timescale 1ns/10ps
`default_nettype none

`include "adc_ctrl_params.svh"

module adc_ctrl_top
  import adc_ctrl_pkg::*;
(
  input  wire                            OPB_Clk,
  input  wire                            rst_n,
  input  wire  [0:31]                    opb_abus,
  input  wire  [0:3]                     opb_be,
  input  wire  [0:31]                    opb_dbus,
  input  wire                            opb_rnw,
  input  wire                            opb_select,
  output logic [0:31]                    sl_dbus,
  output logic                           sl_xferack,
  output logic                           adc3wire_clk,
  output logic                           adc3wire_data,
  output logic [0:`ADC_CS_COUNT-1]       adc3wire_cs,
  output logic                           adc_reset,
  output logic [0:`ADC_TAP_WIDTH-1]      delay_tap,
  output logic [0:`ADC_DELAY_LANES-1]    delay_rst,
  output logic [0:`ADC_SERDES_LANES-1]   iserdes_bitslip,
  output logic [0:`ADC_SERDES_LANES-1]   load_phase_set
);

  logic                         wr_en;
  reg_sel_e                     wr_sel;
  logic [0:3]                   wr_be;
  logic [0:31]                  wr_data;
  logic [0:31]                  rd_3wire;
  logic [0:31]                  rd_ctrl;
  logic [0:`ADC_DELAY_LANES-1]  delay_rst_lvl;
  logic [0:`ADC_SERDES_LANES-1] bitslip_lvl;
  logic [0:`ADC_SERDES_LANES-1] load_phase_lvl;

  opb_reg_slave u_slave (
    .OPB_Clk    (OPB_Clk),
    .rst_n      (rst_n),
    .opb_abus   (opb_abus),
    .opb_be     (opb_be),
    .opb_dbus   (opb_dbus),
    .opb_rnw    (opb_rnw),
    .opb_select (opb_select),
    .rd_3wire   (rd_3wire),
    .rd_ctrl    (rd_ctrl),
    .sl_dbus    (sl_dbus),
    .sl_xferack (sl_xferack),
    .wr_en      (wr_en),
    .wr_sel     (wr_sel),
    .wr_be      (wr_be),
    .wr_data    (wr_data)
  );

  adc_ctrl_regs u_regs (
    .OPB_Clk        (OPB_Clk),
    .rst_n          (rst_n),
    .wr_en          (wr_en),
    .wr_sel         (wr_sel),
    .wr_be          (wr_be),
    .wr_data        (wr_data),
    .rd_3wire       (rd_3wire),
    .rd_ctrl        (rd_ctrl),
    .adc3wire_clk   (adc3wire_clk),
    .adc3wire_data  (adc3wire_data),
    .adc3wire_cs    (adc3wire_cs),
    .adc_reset      (adc_reset),
    .delay_tap      (delay_tap),
    .delay_rst_lvl  (delay_rst_lvl),
    .bitslip_lvl    (bitslip_lvl),
    .load_phase_lvl (load_phase_lvl)
  );

  // Level bits from the control register become single-cycle strobes here.
  delay_strobe_gen u_strobe (
    .OPB_Clk         (OPB_Clk),
    .rst_n           (rst_n),
    .delay_rst_lvl   (delay_rst_lvl),
    .bitslip_lvl     (bitslip_lvl),
    .load_phase_lvl  (load_phase_lvl),
    .delay_rst       (delay_rst),
    .iserdes_bitslip (iserdes_bitslip),
    .load_phase_set  (load_phase_set)
  );

endmodule

`default_nettype wire

/* logic/delay_strobe_gen.sv */
// Pulses follow a rising level by one cycle; a bit must be cleared and set again to re-fire.
`timescale 1ns/10ps
`default_nettype none

`include "adc_ctrl_params.svh"

module delay_strobe_gen (
  input  wire                            OPB_Clk,
  input  wire                            rst_n,
  input  wire  [0:`ADC_DELAY_LANES-1]    delay_rst_lvl,
  input  wire  [0:`ADC_SERDES_LANES-1]   bitslip_lvl,
  input  wire  [0:`ADC_SERDES_LANES-1]   load_phase_lvl,
  output logic [0:`ADC_DELAY_LANES-1]    delay_rst,
  output logic [0:`ADC_SERDES_LANES-1]   iserdes_bitslip,
  output logic [0:`ADC_SERDES_LANES-1]   load_phase_set
);

  localparam int lvl_count = `ADC_DELAY_LANES + 2 * `ADC_SERDES_LANES;

  logic [0:lvl_count-1] lvl_all;
  logic [0:lvl_count-1] prev_q;
  logic [0:lvl_count-1] pulse_q;

  // All levels handled as one vector.
  assign lvl_all = {delay_rst_lvl, bitslip_lvl, load_phase_lvl};

  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      prev_q  <= '0;
      pulse_q <= '0;
    end else begin
      pulse_q <= lvl_all & ~prev_q; // Rising edge only.
      prev_q  <= lvl_all;
    end
  end

  assign delay_rst       = pulse_q[0 +: `ADC_DELAY_LANES];
  assign iserdes_bitslip = pulse_q[`ADC_DELAY_LANES +: `ADC_SERDES_LANES];
  assign load_phase_set  = pulse_q[`ADC_DELAY_LANES + `ADC_SERDES_LANES +: `ADC_SERDES_LANES];

endmodule

`default_nettype wire

/* logic/opb_reg_slave.sv */
// Single-beat OPB slave; no bursts, and addresses outside the window are never acknowledged.
`timescale 1ns/10ps
`default_nettype none

`include "adc_ctrl_params.svh"

module opb_reg_slave
  import adc_ctrl_pkg::*;
(
  input  wire         OPB_Clk,
  input  wire         rst_n,
  input  wire  [0:31] opb_abus,
  input  wire  [0:3]  opb_be,
  input  wire  [0:31] opb_dbus,
  input  wire         opb_rnw,
  input  wire         opb_select,
  input  wire  [0:31] rd_3wire,
  input  wire  [0:31] rd_ctrl,
  output logic [0:31] sl_dbus,
  output logic        sl_xferack,
  output logic        wr_en,
  output reg_sel_e    wr_sel,
  output logic [0:3]  wr_be,
  output logic [0:31] wr_data
);

  opb_state_e  state_q;
  opb_state_e  state_d;
  logic [31:0] addr_off;
  logic        addr_hit;
  logic        req_take;
  reg_sel_e    req_sel;
  logic [0:31] rd_data_q;

  // Full byte address compare against the window.
  assign addr_hit = (opb_abus >= `ADC_BASEADDR) && (opb_abus <= `ADC_HIGHADDR);
  assign addr_off = opb_abus - `ADC_BASEADDR;
  assign req_sel  = reg_sel_e'(addr_off[`ADC_REG_SEL_BIT]);

  // A request is taken only from idle.
  assign req_take = (state_q == ST_IDLE) && opb_select && addr_hit;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (req_take) begin
          state_d = ST_ACK;
        end
      end
      ST_ACK: begin
        state_d = ST_IDLE; // Forced idle cycle.
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign sl_xferack = (state_q == ST_ACK);

  // Write strobe lands on the edge that raises the acknowledge.
  assign wr_en   = req_take && !opb_rnw;
  assign wr_sel  = req_sel;
  assign wr_be   = opb_be;
  assign wr_data = opb_dbus;

  // Read value captured on the accepting edge.
  always_ff @(posedge OPB_Clk) begin
    if (req_take && opb_rnw) begin
      rd_data_q <= (req_sel == REG_CTRL) ? rd_ctrl : rd_3wire;
    end
  end

  // Bus is driven only during the acknowledge so other slaves can share it.
  assign sl_dbus = sl_xferack ? rd_data_q : 32'h0000_0000;

endmodule

`default_nettype wire

/* project.f */
+incdir+include
logic/adc_ctrl_pkg.sv
logic/opb_reg_slave.sv
logic/adc_ctrl_regs.sv
logic/delay_strobe_gen.sv
logic/adc_ctrl_top.sv
dv/adc3wire_model.sv
dv/tb_adc_ctrl.sv
